// File: hw/cdec_consts.svh
`ifndef CDEC_CONSTS_SVH
`define CDEC_CONSTS_SVH

// fetch block geometry
`define CDEC_LANES  2
`define CDEC_SLOT_W 32

//////////////////////////////////////////////////
// rv32 major opcodes
//////////////////////////////////////////////////
`define CDEC_OPC_LOAD   7'h03
`define CDEC_OPC_STORE  7'h23
`define CDEC_OPC_OPIMM  7'h13
`define CDEC_OPC_OP     7'h33
`define CDEC_OPC_LUI    7'h37
`define CDEC_OPC_BRANCH 7'h63
`define CDEC_OPC_JAL    7'h6f
`define CDEC_OPC_JALR   7'h67

`endif

// File: hw/cdec_bus_pkg.sv
`default_nettype none

`include "cdec_consts.svh"

package cdec_bus_pkg;

  // one word as returned by the fetch side
  typedef struct packed {
    logic [`CDEC_SLOT_W-1:0] rdata;
    logic                    err;
  } bus_resp_t;

  // instruction response seen by a decoder lane
  typedef struct packed {
    bus_resp_t bus_resp;
  } inst_resp_t;

  // full fetch block, slot 0 in the low word
  typedef struct packed {
    logic [`CDEC_LANES-1:0][`CDEC_SLOT_W-1:0] slots;
    logic                                     err;
    // slot 0 holds a table pointer, not an opcode
    logic                                     is_ptr;
  } fetch_block_t;

endpackage

`default_nettype wire

// File: hw/cdec_isa_pkg.sv
`default_nettype none

`include "cdec_consts.svh"

package cdec_isa_pkg;

  // full rv32 word and a single rvc parcel
  typedef logic [31:0] instr_word_t;
  typedef logic [15:0] parcel_t;

  // major opcodes used by the expander
  typedef enum logic [6:0] {
    OPCODE_LOAD   = `CDEC_OPC_LOAD,
    OPCODE_STORE  = `CDEC_OPC_STORE,
    OPCODE_OPIMM  = `CDEC_OPC_OPIMM,
    OPCODE_OP     = `CDEC_OPC_OP,
    OPCODE_LUI    = `CDEC_OPC_LUI,
    OPCODE_BRANCH = `CDEC_OPC_BRANCH,
    OPCODE_JAL    = `CDEC_OPC_JAL,
    OPCODE_JALR   = `CDEC_OPC_JALR
  } opcode_e;

  // per-lane decode result
  typedef struct packed {
    cdec_bus_pkg::inst_resp_t instr;
    logic                     is_compressed;
    logic                     illegal;
  } lane_result_t;

  // index of a lane inside the block
  typedef logic [$clog2(`CDEC_LANES)-1:0] lane_idx_t;

endpackage

`default_nettype wire

// File: hw/cdec_fetch_slicer.sv
`timescale 1ns/10ps
`default_nettype none

`include "cdec_consts.svh"

module cdec_fetch_slicer (
  input  logic                                        clk,
  input  logic                                        rst_i,
  input  logic                                        fetch_valid_i,
  input  cdec_bus_pkg::fetch_block_t                  fetch_i,
  output logic                                        lane_valid_o,
  output cdec_bus_pkg::inst_resp_t [`CDEC_LANES-1:0]  lane_resp_o,
  output logic [`CDEC_LANES-1:0]                      lane_is_ptr_o
);

  import cdec_bus_pkg::*;

  // captured block, payload only
  fetch_block_t blk_q;
  logic         valid_q;

  //////////////////////////////////////////////////
  // input register
  //////////////////////////////////////////////////

  // strobe delayed by one cycle
  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= fetch_valid_i;
    end
  end

  // block is held until the next strobe
  always_ff @(posedge clk) begin
    if (fetch_valid_i) begin
      blk_q <= fetch_i;
    end
  end

  assign lane_valid_o = valid_q;

  //////////////////////////////////////////////////
  // per-lane fan out
  //////////////////////////////////////////////////

  for (genvar n = 0; n < `CDEC_LANES; n++) begin : g_lane
    assign lane_resp_o[n].bus_resp.rdata = blk_q.slots[n];
    // bus error applies to the whole block
    assign lane_resp_o[n].bus_resp.err   = blk_q.err;
    // only the first slot can carry a pointer
    assign lane_is_ptr_o[n] = (n == 0) ? blk_q.is_ptr : 1'b0;
  end

endmodule

`default_nettype wire

// File: hw/cdec_compressed_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module cdec_compressed_decoder (
  input  cdec_bus_pkg::inst_resp_t  instr_i,
  input  logic                      instr_is_ptr_i,
  output cdec_bus_pkg::inst_resp_t  instr_o,
  output logic                      is_compressed_o,
  output logic                      illegal_instr_o
);

  import cdec_isa_pkg::*;

  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;

  // low parcel and its register fields
  parcel_t     c;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [4:0]  rdp;
  logic [4:0]  rs1p;
  // sign-extended 6-bit immediate of the ci format
  logic [11:0] imm_ci;
  instr_word_t exp_word;
  logic        exp_illegal;
  logic [2:0]  alu_f3;

  assign c      = instr_i.bus_resp.rdata[15:0];
  assign rd     = c[11:7];
  assign rs2    = c[6:2];
  // compressed registers map onto x8..x15
  assign rdp    = {2'b01, c[4:2]};
  assign rs1p   = {2'b01, c[9:7]};
  assign imm_ci = {{6{c[12]}}, c[12], c[6:2]};

  // funct3 of the c.sub/xor/or/and group
  always_comb begin
    unique case (c[6:5])
      2'b00:   alu_f3 = 3'b000;
      2'b01:   alu_f3 = 3'b100;
      2'b10:   alu_f3 = 3'b110;
      default: alu_f3 = 3'b111;
    endcase
  end

  //////////////////////////////////////////////////
  // rvc expansion
  //////////////////////////////////////////////////

  always_comb begin
    exp_word    = instr_i.bus_resp.rdata;
    exp_illegal = 1'b0;
    unique case (c[1:0])
      // quadrant 0
      2'b00: begin
        // fp loads and stores fall back to the lw shape
        exp_word = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1p, 3'b010, rdp, OPCODE_LOAD};
        unique case (c[15:13])
          3'b000: begin
            // addi4spn, zero offset is reserved
            exp_word    = {2'b0, c[10:7], c[12:11], c[5], c[6], 2'b00,
                           REG_SP, 3'b000, rdp, OPCODE_OPIMM};
            exp_illegal = (c[12:5] == 8'b0);
          end
          3'b010: begin
            // lw keeps the default shape
          end
          3'b110: begin
            exp_word = {5'b0, c[5], c[12], rdp, rs1p, 3'b010,
                        c[11:10], c[6], 2'b00, OPCODE_STORE};
          end
          default: exp_illegal = 1'b1;
        endcase
      end
      // quadrant 1
      2'b01: begin
        unique case (c[15:13])
          3'b000: exp_word = {imm_ci, rd, 3'b000, rd, OPCODE_OPIMM};
          3'b001, 3'b101: begin
            // jal links to ra, j to x0
            exp_word = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                        {9{c[12]}}, 4'b0, ~c[15], OPCODE_JAL};
          end
          3'b010: exp_word = {imm_ci, REG_ZERO, 3'b000, rd, OPCODE_OPIMM};
          3'b011: begin
            if ({c[12], c[6:2]} == 6'b0) begin
              exp_word    = {{15{c[12]}}, c[6:2], rd, OPCODE_LUI};
              exp_illegal = 1'b1;
            end else if (rd == REG_SP) begin
              // addi16sp scales the immediate by 16
              exp_word = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0,
                          REG_SP, 3'b000, REG_SP, OPCODE_OPIMM};
            end else begin
              exp_word = {{15{c[12]}}, c[6:2], rd, OPCODE_LUI};
            end
          end
          3'b100: begin
            unique case (c[11:10])
              2'b00, 2'b01: begin
                // srli or srai, shamt[5] must be clear on rv32
                exp_word    = {1'b0, c[10], 5'b0, c[6:2], rs1p, 3'b101, rs1p, OPCODE_OPIMM};
                exp_illegal = c[12];
              end
              2'b10: exp_word = {imm_ci, rs1p, 3'b111, rs1p, OPCODE_OPIMM};
              default: begin
                exp_word    = {1'b0, (c[6:5] == 2'b00), 5'b0, rdp, rs1p, alu_f3,
                               rs1p, OPCODE_OP};
                // subw, addw and the reserved slots
                exp_illegal = c[12];
              end
            endcase
          end
          default: begin
            // beqz and bnez compare against x0
            exp_word = {{4{c[12]}}, c[6:5], c[2], REG_ZERO, rs1p, 2'b00, c[13],
                        c[11:10], c[4:3], c[12], OPCODE_BRANCH};
          end
        endcase
      end
      // quadrant 2
      2'b10: begin
        // fp stack forms fall back to the lwsp shape
        exp_word = {4'b0, c[3:2], c[12], c[6:4], 2'b00, REG_SP, 3'b010, rd, OPCODE_LOAD};
        unique case (c[15:13])
          3'b000: begin
            exp_word    = {7'b0, rs2, rd, 3'b001, rd, OPCODE_OPIMM};
            exp_illegal = c[12];
          end
          3'b010: exp_illegal = (rd == REG_ZERO);
          3'b100: begin
            if (rs2 != REG_ZERO) begin
              // mv adds to x0, add adds to rd
              exp_word = {7'b0, rs2, (c[12] ? rd : REG_ZERO), 3'b000, rd, OPCODE_OP};
            end else if (!c[12]) begin
              exp_word    = {12'b0, rd, 3'b000, REG_ZERO, OPCODE_JALR};
              exp_illegal = (rd == REG_ZERO);
            end else if (rd == REG_ZERO) begin
              exp_word = 32'h0010_0073;
            end else begin
              exp_word = {12'b0, rd, 3'b000, REG_RA, OPCODE_JALR};
            end
          end
          3'b110: begin
            exp_word = {4'b0, c[8:7], c[12], rs2, REG_SP, 3'b010, c[11:9], 2'b00,
                        OPCODE_STORE};
          end
          default: exp_illegal = 1'b1;
        endcase
      end
      // full 32-bit word
      default: exp_word = instr_i.bus_resp.rdata;
    endcase
  end

  //////////////////////////////////////////////////
  // output select and checks
  //////////////////////////////////////////////////

  always_comb begin
    is_compressed_o = !instr_is_ptr_i && (c[1:0] != 2'b11);
    illegal_instr_o = is_compressed_o && exp_illegal;
    instr_o         = instr_i;
    if (is_compressed_o) begin
      instr_o.bus_resp.rdata = exp_word;
    end
    // a pointer never decodes
    assert (!instr_is_ptr_i || (!is_compressed_o && !illegal_instr_o))
      else $error("pointer word was decoded");
    // uncompressed words and the error bit go through untouched
    assert (is_compressed_o || (instr_o == instr_i))
      else $error("passthrough word was modified");
  end

endmodule

`default_nettype wire

// File: hw/cdec_expand_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "cdec_consts.svh"

module cdec_expand_stage (
  input  logic                                          clk,
  input  logic                                          rst_i,
  input  logic                                          lane_valid_i,
  input  cdec_isa_pkg::lane_result_t [`CDEC_LANES-1:0]  lane_res_i,
  output logic                                          out_valid_o,
  output cdec_isa_pkg::lane_result_t [`CDEC_LANES-1:0]  out_o,
  output logic                                          any_illegal_o,
  output cdec_isa_pkg::lane_idx_t                       first_illegal_o
);

  import cdec_isa_pkg::*;

  lane_result_t [`CDEC_LANES-1:0] res_q;
  logic                           valid_q;
  logic                           any_q;
  logic                           any_d;
  lane_idx_t                      first_d;
  lane_idx_t                      first_q;

  // lowest illegal lane wins, scan from the top down
  always_comb begin
    any_d   = 1'b0;
    first_d = '0;
    for (int n = `CDEC_LANES - 1; n >= 0; n--) begin
      if (lane_res_i[n].illegal) begin
        any_d   = 1'b1;
        first_d = lane_idx_t'(n);
      end
    end
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      any_q   <= 1'b0;
    end else begin
      valid_q <= lane_valid_i;
      // summary only counts for a live block
      any_q   <= lane_valid_i && any_d;
    end
  end

  always_ff @(posedge clk) begin
    if (lane_valid_i) begin
      res_q   <= lane_res_i;
      first_q <= first_d;
    end
  end

  assign out_valid_o     = valid_q;
  assign out_o           = res_q;
  assign any_illegal_o   = any_q;
  assign first_illegal_o = first_q;

  // summary never flags an empty cycle
  assert property (@(posedge clk) disable iff (rst_i) any_illegal_o |-> out_valid_o)
    else $error("illegal summary without valid output");

  // named lane really is the offender
  assert property (@(posedge clk) disable iff (rst_i)
                   any_illegal_o |-> out_o[first_illegal_o].illegal)
    else $error("first illegal lane does not carry the flag");

endmodule

`default_nettype wire

// File: hw/cdec_expand_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "cdec_consts.svh"

module cdec_expand_top (
  input  logic                                          clk,
  input  logic                                          rst_i,
  input  logic                                          fetch_valid_i,
  input  cdec_bus_pkg::fetch_block_t                    fetch_i,
  output logic                                          out_valid_o,
  output cdec_isa_pkg::lane_result_t [`CDEC_LANES-1:0]  out_o,
  output logic                                          any_illegal_o,
  output cdec_isa_pkg::lane_idx_t                       first_illegal_o
);

  import cdec_bus_pkg::*;
  import cdec_isa_pkg::*;

  logic                           lane_valid;
  inst_resp_t   [`CDEC_LANES-1:0] lane_resp;
  logic         [`CDEC_LANES-1:0] lane_is_ptr;
  lane_result_t [`CDEC_LANES-1:0] lane_res;

  // register stage one
  cdec_fetch_slicer u_slicer (
    .clk           (clk),
    .rst_i         (rst_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_i       (fetch_i),
    .lane_valid_o  (lane_valid),
    .lane_resp_o   (lane_resp),
    .lane_is_ptr_o (lane_is_ptr)
  );

  // one expander per slot, outputs land in the result struct
  for (genvar n = 0; n < `CDEC_LANES; n++) begin : g_dec
    cdec_compressed_decoder u_dec (
      .instr_i         (lane_resp[n]),
      .instr_is_ptr_i  (lane_is_ptr[n]),
      .instr_o         (lane_res[n].instr),
      .is_compressed_o (lane_res[n].is_compressed),
      .illegal_instr_o (lane_res[n].illegal)
    );
  end

  // register stage two
  cdec_expand_stage u_stage (
    .clk             (clk),
    .rst_i           (rst_i),
    .lane_valid_i    (lane_valid),
    .lane_res_i      (lane_res),
    .out_valid_o     (out_valid_o),
    .out_o           (out_o),
    .any_illegal_o   (any_illegal_o),
    .first_illegal_o (first_illegal_o)
  );

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset held for a fixed number of edges, dropped just after an edge
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// File: dv/tb_cdec_expand.sv
`timescale 1ns/10ps
`default_nettype none

`include "cdec_consts.svh"

module tb_cdec_expand;

  import cdec_bus_pkg::*;
  import cdec_isa_pkg::*;

  typedef lane_result_t [`CDEC_LANES-1:0] block_res_t;

  // stimulus modes, one per test
  localparam int M_IDLE   = 0;
  localparam int M_PASS   = 1;
  localparam int M_EXP    = 2;
  localparam int M_ILL    = 3;
  localparam int M_PTR    = 4;
  localparam int M_STREAM = 5;

  // cycles of stimulus per test
  localparam int N_IDLE   = 5;
  localparam int N_PASS   = 40;
  localparam int N_EXP    = 80;
  localparam int N_ILL    = 40;
  localparam int N_PTR    = 20;
  localparam int N_STREAM = 80;
  localparam int N_TOTAL  = N_IDLE + N_PASS + N_EXP + N_ILL + N_PTR + N_STREAM;
  localparam int LIMIT    = 2 * N_TOTAL + 20;

  // legal rvc shapes, random bits fill everything outside the mask
  localparam logic [15:0] LEGAL_MASK [18] = '{
    16'hE003, 16'hE003, 16'hE003, 16'hE003, 16'hE003, 16'hE003, 16'hE003, 16'hFC03,
    16'hFC03, 16'hEC03, 16'hFC03, 16'hE003, 16'hE003, 16'hF003, 16'hF003, 16'hF07F,
    16'hF07F, 16'hFFFF};
  // addi lw sw j jal beqz bnez srli srai andi alu lwsp swsp mv add jr jalr ebreak
  localparam logic [15:0] LEGAL_VAL [18] = '{
    16'h0001, 16'h4000, 16'hC000, 16'hA001, 16'h2001, 16'hC001, 16'hE001, 16'h8001,
    16'h8401, 16'h8801, 16'h8C01, 16'h4002, 16'hC002, 16'h8002, 16'h9002, 16'h8002,
    16'h9002, 16'h9002};
  // reserved or unsupported shapes
  localparam logic [15:0] ILL_MASK [12] = '{
    16'hFFE3, 16'hE003, 16'hE003, 16'hE003, 16'hF07F, 16'hFC03, 16'hFC03, 16'hFC03,
    16'hEF83, 16'hFFFF, 16'hF003, 16'hE003};
  // addi4spn0 fld flw fsw lui0 srli12 srai12 subw lwsp0 jr0 slli12 fswsp
  localparam logic [15:0] ILL_VAL [12] = '{
    16'h0000, 16'h2000, 16'h6000, 16'hE000, 16'h6001, 16'h9001, 16'h9401, 16'h9C01,
    16'h4002, 16'h8002, 16'h1002, 16'hE002};

  logic            clk;
  logic            rst;
  logic            fetch_valid;
  fetch_block_t    fetch_blk;
  logic            out_valid;
  block_res_t      out_res;
  logic            any_illegal;
  lane_idx_t       first_illegal;

  logic [31:0]     rng_q = 32'd12896;
  block_res_t      exp_q[$];
  block_res_t      exp_blk;
  lane_result_t    exp_l;
  lane_result_t    act_l;
  logic            exp_any;
  lane_idx_t       exp_first;
  logic [1:0]      valid_hist;
  string           cur_test = "reset";
  int              errors = 0;
  int              checks = 0;
  int              tests_failed = 0;
  int              cycle_cnt = 0;

  tb_clk_gen #(.RST_CYCLES(2)) u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  cdec_expand_top u_cdec_expand_top (
    .clk             (clk),
    .rst_i           (rst),
    .fetch_valid_i   (fetch_valid),
    .fetch_i         (fetch_blk),
    .out_valid_o     (out_valid),
    .out_o           (out_res),
    .any_illegal_o   (any_illegal),
    .first_illegal_o (first_illegal)
  );

  //////////////////////////////////////////////////
  // random numbers and rv32 encoders
  //////////////////////////////////////////////////

  // xorshift32 step
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_q;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_q = x;
    return x;
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [6:0] op);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  // branch offset is in bytes, bit 0 dropped
  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `CDEC_OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, `CDEC_OPC_JAL};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, `CDEC_OPC_LUI};
  endfunction

  //////////////////////////////////////////////////
  // reference expansion model
  //////////////////////////////////////////////////

  function automatic lane_result_t model_lane(input logic [31:0] w, input logic err,
                                              input logic ptr);
    lane_result_t res;
    logic [15:0]  p;
    logic [4:0]   rd_f;
    logic [4:0]   rs2_f;
    logic [4:0]   rdc;
    logic [4:0]   rs1c;
    logic [11:0]  ci;
    logic [9:0]   imm10;
    logic [7:0]   off8;
    logic [6:0]   off7;
    logic [11:0]  off12;
    logic [8:0]   off9;
    logic [2:0]   f3;
    logic [31:0]  x;
    logic         bad;
    p     = w[15:0];
    rd_f  = p[11:7];
    rs2_f = p[6:2];
    // primed registers are x8..x15
    rdc   = {2'b01, p[4:2]};
    rs1c  = {2'b01, p[9:7]};
    ci    = 12'($signed({p[12], p[6:2]}));
    res.instr.bus_resp.rdata = w;
    res.instr.bus_resp.err   = err;
    res.is_compressed        = 1'b0;
    res.illegal              = 1'b0;
    // full words and table pointers go through as they are
    if (ptr || p[1:0] == 2'b11) begin
      return res;
    end
    x   = '0;
    bad = 1'b0;
    // key is quadrant then funct3
    case ({p[1:0], p[15:13]})
      5'b00_000: begin
        imm10 = {p[10:7], p[12:11], p[5], p[6], 2'b00};
        bad   = (imm10 == 10'd0);
        x     = enc_i(12'(imm10), 5'd2, 3'd0, rdc, `CDEC_OPC_OPIMM);
      end
      5'b00_010: begin
        off7 = {p[5], p[12:10], p[6], 2'b00};
        x    = enc_i(12'(off7), rs1c, 3'd2, rdc, `CDEC_OPC_LOAD);
      end
      5'b00_110: begin
        off7 = {p[5], p[12:10], p[6], 2'b00};
        x    = enc_s(12'(off7), rdc, rs1c, 3'd2, `CDEC_OPC_STORE);
      end
      5'b01_000: x = enc_i(ci, rd_f, 3'd0, rd_f, `CDEC_OPC_OPIMM);
      5'b01_001, 5'b01_101: begin
        off12 = {p[12], p[8], p[10:9], p[6], p[7], p[2], p[11], p[5:3], 1'b0};
        // c.jal writes ra, c.j writes x0
        x     = enc_j(21'($signed(off12)), p[15] ? 5'd0 : 5'd1);
      end
      5'b01_010: x = enc_i(ci, 5'd0, 3'd0, rd_f, `CDEC_OPC_OPIMM);
      5'b01_011: begin
        bad = ({p[12], p[6:2]} == 6'd0);
        if (rd_f == 5'd2) begin
          // addi16sp
          imm10 = {p[12], p[4:3], p[5], p[2], p[6], 4'b0000};
          x     = enc_i(12'($signed(imm10)), 5'd2, 3'd0, 5'd2, `CDEC_OPC_OPIMM);
        end else begin
          x = enc_u(20'($signed({p[12], p[6:2]})), rd_f);
        end
      end
      5'b01_100: begin
        case (p[11:10])
          2'b00, 2'b01: begin
            bad = p[12];
            x   = enc_r({1'b0, p[10], 5'b00000}, p[6:2], rs1c, 3'd5, rs1c, `CDEC_OPC_OPIMM);
          end
          2'b10: x = enc_i(ci, rs1c, 3'd7, rs1c, `CDEC_OPC_OPIMM);
          default: begin
            bad = p[12];
            case (p[6:5])
              2'b00:   f3 = 3'd0;
              2'b01:   f3 = 3'd4;
              2'b10:   f3 = 3'd6;
              default: f3 = 3'd7;
            endcase
            x = enc_r((p[6:5] == 2'b00) ? 7'h20 : 7'h00, rdc, rs1c, f3, rs1c, `CDEC_OPC_OP);
          end
        endcase
      end
      5'b01_110, 5'b01_111: begin
        off9 = {p[12], p[6:5], p[2], p[11:10], p[4:3], 1'b0};
        x    = enc_b(13'($signed(off9)), 5'd0, rs1c, {2'b00, p[13]});
      end
      5'b10_000: begin
        bad = p[12];
        x   = enc_r(7'h00, p[6:2], rd_f, 3'd1, rd_f, `CDEC_OPC_OPIMM);
      end
      5'b10_010: begin
        off8 = {p[3:2], p[12], p[6:4], 2'b00};
        bad  = (rd_f == 5'd0);
        x    = enc_i(12'(off8), 5'd2, 3'd2, rd_f, `CDEC_OPC_LOAD);
      end
      5'b10_100: begin
        if (!p[12]) begin
          if (rs2_f == 5'd0) begin
            bad = (rd_f == 5'd0);
            x   = enc_i(12'd0, rd_f, 3'd0, 5'd0, `CDEC_OPC_JALR);
          end else begin
            x = enc_r(7'h00, rs2_f, 5'd0, 3'd0, rd_f, `CDEC_OPC_OP);
          end
        end else if (rs2_f != 5'd0) begin
          x = enc_r(7'h00, rs2_f, rd_f, 3'd0, rd_f, `CDEC_OPC_OP);
        end else if (rd_f == 5'd0) begin
          // ebreak
          x = 32'h0010_0073;
        end else begin
          x = enc_i(12'd0, rd_f, 3'd0, 5'd1, `CDEC_OPC_JALR);
        end
      end
      5'b10_110: begin
        off8 = {p[8:7], p[12:9], 2'b00};
        x    = enc_s(12'(off8), rs2_f, 5'd2, 3'd2, `CDEC_OPC_STORE);
      end
      default: bad = 1'b1;
    endcase
    res.instr.bus_resp.rdata = x;
    res.is_compressed        = 1'b1;
    res.illegal              = bad;
    return res;
  endfunction

  function automatic block_res_t model_block(input fetch_block_t b);
    block_res_t r;
    for (int n = 0; n < `CDEC_LANES; n++) begin
      // only slot 0 can be a pointer
      r[n] = model_lane(b.slots[n], b.err, (n == 0) ? b.is_ptr : 1'b0);
    end
    return r;
  endfunction

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  // kind 0 full word, 1 legal rvc, 2 illegal rvc, 3 anything
  function automatic logic [31:0] rand_slot(input int kind);
    logic [31:0] hi;
    logic [31:0] r;
    logic [31:0] word;
    int          idx;
    hi = next_rand();
    r  = next_rand();
    case (kind)
      0: word = hi | 32'h3;
      1: begin
        idx  = int'(r[31:16]) % 18;
        word = {hi[31:16], (r[15:0] & ~LEGAL_MASK[idx]) | LEGAL_VAL[idx]};
      end
      2: begin
        idx  = int'(r[31:16]) % 12;
        word = {hi[31:16], (r[15:0] & ~ILL_MASK[idx]) | ILL_VAL[idx]};
      end
      default: word = hi;
    endcase
    return word;
  endfunction

  function automatic fetch_block_t make_block(input int kind0, input int kind1,
                                              input logic ptr);
    fetch_block_t b;
    logic [31:0]  r;
    for (int n = 0; n < `CDEC_LANES; n++) begin
      b.slots[n] = rand_slot((n == 0) ? kind0 : kind1);
    end
    r        = next_rand();
    b.err    = r[0];
    b.is_ptr = ptr;
    return b;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expv,
                             input logic [63:0] actv);
    checks++;
    if (expv !== actv) begin
      $display("[FAIL] %s expected %h actual %h", name, expv, actv);
      errors++;
    end
  endtask

  // inputs change 1 ns after the edge, model result queued with the strobe
  task automatic drive_block(input logic vld, input fetch_block_t blk);
    @(posedge clk);
    #1;
    fetch_valid = vld;
    fetch_blk   = blk;
    if (vld) begin
      exp_q.push_back(model_block(blk));
    end
  endtask

  task automatic run_test(input string name, input int cycles, input int mode);
    logic [31:0]  r;
    logic         vld;
    fetch_block_t blk;
    int           base;
    cur_test = name;
    base     = errors;
    for (int i = 0; i < cycles; i++) begin
      r   = next_rand();
      vld = 1'b1;
      case (mode)
        M_IDLE: begin
          vld = 1'b0;
          blk = make_block(3, 3, 1'b0);
        end
        M_PASS:  blk = make_block(0, 0, 1'b0);
        M_EXP:   blk = make_block(1, 1, 1'b0);
        M_ILL:   blk = make_block(r[0] ? 2 : 0, r[1] ? 2 : 0, 1'b0);
        M_PTR:   blk = make_block(r[0] ? 2 : 1, 1, 1'b1);
        default: begin
          // gaps in roughly one cycle of four
          vld = (r[1:0] != 2'b00);
          blk = make_block(int'(r[3:2]), int'(r[5:4]), r[6]);
        end
      endcase
      drive_block(vld, blk);
    end
    drive_block(1'b0, fetch_blk);
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    if (errors == base) begin
      $display("test %-12s ok", name);
    end else begin
      $display("test %-12s failed with %0d errors", name, errors - base);
      tests_failed++;
    end
  endtask

  //////////////////////////////////////////////////
  // output monitor
  //////////////////////////////////////////////////

  // strobes as the slicer captured them
  always @(posedge clk) begin
    if (rst) begin
      valid_hist <= 2'b00;
    end else begin
      valid_hist <= {valid_hist[0], fetch_valid};
    end
  end

  // outputs settle after the edge, sampled half a period later
  always @(negedge clk) begin
    if (!rst) begin
      check_value({cur_test, " out_valid"}, 64'(valid_hist[1]), 64'(out_valid));
      if (!out_valid) begin
        check_value({cur_test, " idle any_illegal"}, 64'(1'b0), 64'(any_illegal));
      end else if (exp_q.size() == 0) begin
        $display("%s: output valid with no block in flight", cur_test);
        errors++;
      end else begin
        exp_blk   = exp_q.pop_front();
        exp_any   = 1'b0;
        exp_first = '0;
        for (int n = 0; n < `CDEC_LANES; n++) begin
          exp_l = exp_blk[n];
          act_l = out_res[n];
          if (exp_l.illegal && !exp_any) begin
            exp_any   = 1'b1;
            exp_first = lane_idx_t'(n);
          end
          // the word of an illegal lane carries no meaning
          if (exp_l.illegal) begin
            exp_l.instr.bus_resp.rdata = '0;
            act_l.instr.bus_resp.rdata = '0;
          end
          check_value($sformatf("%s lane%0d", cur_test, n), 64'(exp_l), 64'(act_l));
        end
        check_value({cur_test, " any_illegal"}, 64'(exp_any), 64'(any_illegal));
        if (exp_any) begin
          check_value({cur_test, " first_illegal"}, 64'(exp_first), 64'(first_illegal));
        end
      end
    end
  end

  // watchdog
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > LIMIT) begin
      $display("timeout: run went past %0d cycles", LIMIT);
      $display("Done: errors found");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    fetch_valid = 1'b0;
    fetch_blk   = '0;
    wait (rst === 1'b0);
    run_test("reset_idle", N_IDLE, M_IDLE);
    run_test("passthrough", N_PASS, M_PASS);
    run_test("expansion", N_EXP, M_EXP);
    run_test("illegal", N_ILL, M_ILL);
    run_test("pointer", N_PTR, M_PTR);
    run_test("streaming", N_STREAM, M_STREAM);
    $display("tests: 6, failed: %0d, checks: %0d, errors: %0d",
             tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hw
hw/cdec_bus_pkg.sv
hw/cdec_isa_pkg.sv
hw/cdec_fetch_slicer.sv
hw/cdec_compressed_decoder.sv
hw/cdec_expand_stage.sv
hw/cdec_expand_top.sv
dv/tb_clk_gen.sv
dv/tb_cdec_expand.sv

// File: Makefile
# Verilator build and run for the compressed expansion front end

VERILATOR ?= verilator
TOP       ?= tb_cdec_expand
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Done: no errors

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hw/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
